/* logic/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [cpu_isa_pkg::word_width-1:0] y,
    input  logic [cpu_isa_pkg::word_width-1:0] bus,
    input  cpu_ctrl_pkg::alu_op_t              op,
    output logic [cpu_isa_pkg::word_width-1:0] result
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [4:0]              count;
    logic [2*word_width-1:0] doubled;
    logic [2*word_width-1:0] ror_wide;
    logic [2*word_width-1:0] rol_wide;

    assign count    = bus[4:0];  // shift amount
    assign doubled  = {y, y};    // rotates fall out of a double-width shift
    assign ror_wide = doubled >> count;
    assign rol_wide = doubled << count;

    always_comb begin
        case (op)
            fn_add:  result = y + bus;
            fn_sub:  result = y - bus;
            fn_and:  result = y & bus;
            fn_or:   result = y | bus;
            fn_shr:  result = y >> count;
            fn_shra: result = $signed(y) >>> count;
            fn_shl:  result = y << count;
            fn_ror:  result = ror_wide[word_width-1:0];
            fn_rol:  result = rol_wide[2*word_width-1:word_width];
            fn_neg:  result = -bus;  // unary ops ignore Y
            fn_not:  result = ~bus;
            default: result = y + bus;
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/10ps

module control_unit (
    input  logic   clk,
    input  logic   reset,
    input  logic   stop,
    ctrl_bus_if.ctrl ctl
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    step_t   state;
    step_t   next_state;
    opcode_t opcode;

    // during fetch2 the datapath shows the word being latched into IR
    assign opcode = opcode_t'(ctl.ir[op_hi:op_lo]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= reset_step;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            reset_step: next_state = fetch0;
            fetch0:     next_state = stop ? fetch0 : fetch1;  // hold here while stopped
            fetch1:     next_state = fetch2;
            fetch2: begin
                case (opcode)
                    op_ld:   next_state = ld3;
                    op_ldi:  next_state = ldi3;
                    op_st:   next_state = st3;
                    op_add, op_sub, op_and, op_or,
                    op_shr, op_shra, op_shl, op_ror, op_rol:
                        next_state = alu3;
                    op_addi, op_andi, op_ori:
                        next_state = imm3;
                    op_neg, op_not:
                        next_state = un3;
                    op_br:   next_state = br3;
                    default: next_state = nop3;  // nop and anything unknown
                endcase
            end
            ld3:  next_state = ld4;
            ld4:  next_state = ld5;
            ld5:  next_state = ld6;
            ld6:  next_state = ld7;
            ldi3: next_state = ldi4;
            ldi4: next_state = ldi5;
            st3:  next_state = st4;
            st4:  next_state = st5;
            st5:  next_state = st6;
            st6:  next_state = st7;
            alu3: next_state = alu4;
            alu4: next_state = alu5;
            imm3: next_state = imm4;
            imm4: next_state = imm5;
            un3:  next_state = un4;
            br3:  next_state = br4;
            br4:  next_state = br5;
            br5:  next_state = br6;
            default: next_state = fetch0;  // last step of every instruction
        endcase
    end

    always_comb begin
        ctl.pc_enable    = 1'b0;
        ctl.ir_enable    = 1'b0;
        ctl.y_enable     = 1'b0;
        ctl.z_enable     = 1'b0;
        ctl.mar_enable   = 1'b0;
        ctl.mdr_enable   = 1'b0;
        ctl.con_enable   = 1'b0;
        ctl.r_out        = 1'b0;
        ctl.ba_out       = 1'b0;
        ctl.c_out        = 1'b0;
        ctl.zlo_out      = 1'b0;
        ctl.mdr_out      = 1'b0;
        ctl.pc_out       = 1'b0;
        ctl.gra          = 1'b0;
        ctl.grb          = 1'b0;
        ctl.grc          = 1'b0;
        ctl.r_in         = 1'b0;
        ctl.read         = 1'b0;
        ctl.ram_write    = 1'b0;
        ctl.pc_increment = 1'b0;
        ctl.y_clr        = 1'b0;
        ctl.alu_add      = 1'b0;
        case (state)
            fetch0: begin
                if (!stop) begin
                    ctl.pc_out       = 1'b1;  // MAR <= PC, Z <= PC + 1
                    ctl.mar_enable   = 1'b1;
                    ctl.pc_increment = 1'b1;
                    ctl.z_enable     = 1'b1;
                    ctl.y_clr        = 1'b1;
                end
            end
            fetch1: begin
                ctl.zlo_out    = 1'b1;
                ctl.pc_enable  = 1'b1;
                ctl.read       = 1'b1;
                ctl.mdr_enable = 1'b1;
            end
            fetch2: begin
                ctl.mdr_out   = 1'b1;
                ctl.ir_enable = 1'b1;
            end
            // base register into Y, r0 reads as zero
            ld3, ldi3, st3: begin
                ctl.grb      = 1'b1;
                ctl.ba_out   = 1'b1;
                ctl.y_enable = 1'b1;
            end
            ld4, ldi4, st4, br5: begin
                ctl.c_out    = 1'b1;
                ctl.z_enable = 1'b1;
                ctl.alu_add  = 1'b1;  // address or branch target
            end
            ld5, st5: begin
                ctl.zlo_out    = 1'b1;
                ctl.mar_enable = 1'b1;
            end
            ld6: begin
                ctl.read       = 1'b1;
                ctl.mdr_enable = 1'b1;
            end
            ld7: begin
                ctl.mdr_out = 1'b1;
                ctl.gra     = 1'b1;
                ctl.r_in    = 1'b1;
            end
            ldi5, alu5, imm5, un4: begin
                ctl.zlo_out = 1'b1;  // result back to ra
                ctl.gra     = 1'b1;
                ctl.r_in    = 1'b1;
            end
            st6: begin
                ctl.gra        = 1'b1;  // store data is ra
                ctl.r_out      = 1'b1;
                ctl.mdr_enable = 1'b1;
            end
            st7: ctl.ram_write = 1'b1;
            alu3, imm3: begin
                ctl.grb      = 1'b1;
                ctl.r_out    = 1'b1;
                ctl.y_enable = 1'b1;
            end
            alu4: begin
                ctl.grc      = 1'b1;
                ctl.r_out    = 1'b1;
                ctl.z_enable = 1'b1;
            end
            imm4: begin
                ctl.c_out    = 1'b1;
                ctl.z_enable = 1'b1;
            end
            un3: begin
                ctl.grb      = 1'b1;
                ctl.r_out    = 1'b1;
                ctl.z_enable = 1'b1;
            end
            br3: begin
                ctl.gra        = 1'b1;
                ctl.r_out      = 1'b1;
                ctl.con_enable = 1'b1;
            end
            br4: begin
                ctl.pc_out   = 1'b1;
                ctl.y_enable = 1'b1;
            end
            br6: begin
                ctl.zlo_out   = 1'b1;
                ctl.pc_enable = ctl.con_ff;  // taken only on a met condition
            end
            default: ;
        endcase
    end

    // memory never sees a read and a write in the same step
    assert property (@(posedge clk) disable iff (reset) !(ctl.read && ctl.ram_write));

    assert property (@(posedge clk) disable iff (reset) state inside {[reset_step:nop3]});

endmodule

/* logic/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // one control step per clock, numbered in order so nop3 is the last one
    typedef enum logic [5:0] {
        reset_step,
        fetch0,
        fetch1,
        fetch2,
        ld3,
        ld4,
        ld5,
        ld6,
        ld7,
        ldi3,
        ldi4,
        ldi5,
        st3,
        st4,
        st5,
        st6,
        st7,
        alu3,   // two-register ops
        alu4,
        alu5,
        imm3,   // addi, andi, ori
        imm4,
        imm5,
        un3,    // neg and not
        un4,
        br3,
        br4,
        br5,
        br6,
        nop3
    } step_t;

    typedef enum logic [3:0] {
        fn_add,
        fn_sub,
        fn_and,
        fn_or,
        fn_shr,
        fn_shra,
        fn_shl,
        fn_ror,
        fn_rol,
        fn_neg,
        fn_not
    } alu_op_t;

endpackage

/* logic/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int word_width = 32;

    // instruction fields, msb and lsb of each
    localparam int op_hi = 31;
    localparam int op_lo = 27;
    localparam int ra_hi = 26;
    localparam int ra_lo = 23;
    localparam int rb_hi = 22;
    localparam int rb_lo = 19;
    localparam int rc_hi = 18;
    localparam int rc_lo = 15;
    localparam int const_hi = 18;  // sign bit of the constant
    localparam int const_lo = 0;
    localparam int cond_hi = 20;   // branch condition sits over rb
    localparam int cond_lo = 19;

    // gaps in the codes belong to mul, div, jr, jal and the port ops
    typedef enum logic [4:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_shr  = 5'd5,
        op_shra = 5'd6,
        op_shl  = 5'd7,
        op_ror  = 5'd8,
        op_rol  = 5'd9,
        op_and  = 5'd10,
        op_or   = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_neg  = 5'd17,
        op_not  = 5'd18,
        op_br   = 5'd19,
        op_nop  = 5'd26
    } opcode_t;

    // tested against the value of ra
    typedef enum logic [1:0] {
        cond_zero     = 2'd0,
        cond_nonzero  = 2'd1,
        cond_positive = 2'd2,  // sign bit clear
        cond_negative = 2'd3
    } cond_t;

endpackage

/* logic/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
    parameter int addr_width = 9
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stop,
    output logic [addr_width-1:0]              mem_addr,
    input  logic [cpu_isa_pkg::word_width-1:0] mem_rdata,
    output logic [cpu_isa_pkg::word_width-1:0] mem_wdata,
    output logic                               mem_read,
    output logic                               mem_write
);

    ctrl_bus_if ctl ();

    control_unit u_ctrl (
        .clk   (clk),
        .reset (reset),
        .stop  (stop),
        .ctl   (ctl)
    );

    datapath #(
        .addr_width (addr_width)
    ) u_dp (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

endmodule

/* logic/ctrl_bus_if.sv */
`timescale 1ns/10ps

interface ctrl_bus_if;

    // register loads
    logic pc_enable, ir_enable, y_enable, z_enable;
    logic mar_enable, mdr_enable, con_enable;

    // bus drivers, one at a time
    logic r_out, ba_out, c_out, zlo_out, mdr_out, pc_out;

    logic gra, grb, grc, r_in;  // register file field select
    logic read, ram_write;
    logic pc_increment, y_clr, alu_add;

    // back from the datapath
    logic [cpu_isa_pkg::word_width-1:0] ir;
    logic con_ff;

    modport ctrl (
        output pc_enable, ir_enable, y_enable, z_enable, mar_enable, mdr_enable, con_enable,
        output r_out, ba_out, c_out, zlo_out, mdr_out, pc_out,
        output gra, grb, grc, r_in, read, ram_write,
        output pc_increment, y_clr, alu_add,
        input  ir, con_ff
    );

    modport dp (
        input  pc_enable, ir_enable, y_enable, z_enable, mar_enable, mdr_enable, con_enable,
        input  r_out, ba_out, c_out, zlo_out, mdr_out, pc_out,
        input  gra, grb, grc, r_in, read, ram_write,
        input  pc_increment, y_clr, alu_add,
        output ir, con_ff
    );

endinterface

/* logic/datapath.sv */
`timescale 1ns/10ps

module datapath #(
    parameter int addr_width = 9
) (
    input  logic                               clk,
    input  logic                               reset,
    ctrl_bus_if.dp                             ctl,
    output logic [addr_width-1:0]              mem_addr,
    output logic [cpu_isa_pkg::word_width-1:0] mem_wdata,
    input  logic [cpu_isa_pkg::word_width-1:0] mem_rdata,
    output logic                               mem_read,
    output logic                               mem_write
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [word_width-1:0] regs [16];
    logic [word_width-1:0] pc_q, ir_q, mdr_q, y_q, z_q;
    logic [addr_width-1:0] mar_q;
    logic                  con_q;

    logic [word_width-1:0] bus;
    logic [word_width-1:0] c_sext;
    logic [word_width-1:0] alu_result;
    logic [3:0]            reg_idx;
    logic                  cond_met;
    alu_op_t               alu_op;
    logic [5:0]            bus_src;
    logic                  bus_load;

    // field select for the register file
    always_comb begin
        if (ctl.gra) reg_idx = ir_q[ra_hi:ra_lo];
        else if (ctl.grb) reg_idx = ir_q[rb_hi:rb_lo];
        else if (ctl.grc) reg_idx = ir_q[rc_hi:rc_lo];
        else reg_idx = '0;
    end

    assign c_sext = {{(word_width-const_hi-1){ir_q[const_hi]}}, ir_q[const_hi:const_lo]};

    always_comb begin
        bus = '0;
        if (ctl.r_out) bus = regs[reg_idx];
        else if (ctl.ba_out) bus = (reg_idx == 4'd0) ? '0 : regs[reg_idx];  // r0 as base means 0
        else if (ctl.c_out) bus = c_sext;
        else if (ctl.zlo_out) bus = z_q;
        else if (ctl.mdr_out) bus = mdr_q;
        else if (ctl.pc_out) bus = pc_q;
    end

    always_comb begin
        case (cond_t'(ir_q[cond_hi:cond_lo]))
            cond_zero:     cond_met = (bus == '0);
            cond_nonzero:  cond_met = (bus != '0);
            cond_positive: cond_met = ~bus[word_width-1];
            default:       cond_met = bus[word_width-1];
        endcase
    end

    always_comb begin
        if (ctl.alu_add) begin
            alu_op = fn_add;
        end else begin
            case (opcode_t'(ir_q[op_hi:op_lo]))
                op_sub:          alu_op = fn_sub;
                op_and, op_andi: alu_op = fn_and;
                op_or, op_ori:   alu_op = fn_or;
                op_shr:          alu_op = fn_shr;
                op_shra:         alu_op = fn_shra;
                op_shl:          alu_op = fn_shl;
                op_ror:          alu_op = fn_ror;
                op_rol:          alu_op = fn_rol;
                op_neg:          alu_op = fn_neg;
                op_not:          alu_op = fn_not;
                default:         alu_op = fn_add;  // add and addi
            endcase
        end
    end

    alu u_alu (
        .y      (y_q),
        .bus    (bus),
        .op     (alu_op),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (ctl.r_in) regs[reg_idx] <= bus;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q  <= '0;  // program starts at word 0
            ir_q  <= '0;
            con_q <= 1'b0;
        end else begin
            if (ctl.pc_enable) pc_q <= bus;
            if (ctl.ir_enable) ir_q <= bus;
            if (ctl.con_enable) con_q <= cond_met;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.mar_enable) mar_q <= bus[addr_width-1:0];
        if (ctl.mdr_enable) mdr_q <= ctl.read ? mem_rdata : bus;
        if (ctl.y_clr) y_q <= '0;
        else if (ctl.y_enable) y_q <= bus;
        if (ctl.z_enable) z_q <= ctl.pc_increment ? pc_q + 1'b1 : alu_result;
    end

    // word on the bus reaches the decoder in the same step it enters IR
    assign ctl.ir     = ctl.ir_enable ? bus : ir_q;
    assign ctl.con_ff = con_q;

    assign mem_addr  = mar_q;
    assign mem_wdata = mdr_q;
    assign mem_read  = ctl.read;
    assign mem_write = ctl.ram_write;

    assign bus_src  = {ctl.r_out, ctl.ba_out, ctl.c_out, ctl.zlo_out, ctl.mdr_out, ctl.pc_out};
    assign bus_load = ctl.r_in | ctl.y_enable | ctl.z_enable | ctl.mar_enable | ctl.pc_enable
                    | ctl.ir_enable | ctl.con_enable | (ctl.mdr_enable & ~ctl.read);

    // any register that samples the bus sees exactly one driver
    assert property (@(posedge clk) disable iff (reset)
        $onehot0(bus_src) && (!bus_load || $onehot(bus_src)));

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f verilog.f -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* test/cpu_checker.sv */
`timescale 1ns/10ps

module cpu_checker #(
    parameter int addr_width = 9
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  image_ready,
    input  logic [31:0]           image [1 << addr_width],
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [31:0]           mem_wdata,
    output int                    seen_count,
    output int                    expect_count,
    output int                    error_count
);
    import cpu_isa_pkg::*;

    localparam int depth = 1 << addr_width;

    logic [addr_width-1:0] exp_addr [$];
    logic [31:0]           exp_data [$];
    int                    seen = 0;
    int                    expected = 0;
    int                    errors = 0;
    bit                    model_done = 1'b0;

    assign seen_count   = seen;
    assign expect_count = expected;
    assign error_count  = errors;

    // instruction-level model, one loop pass per instruction
    function automatic int run_model();
        logic [31:0]        m [depth];
        logic [31:0]        r [16];
        logic [31:0]        pc, w, c, base, ea, v;
        logic [3:0]         ra, rb, rc;
        logic [4:0]         n;
        logic signed [31:0] sv;
        logic               taken;
        bit                 halted;
        int                 i;
        int                 steps;
        for (i = 0; i < depth; i++) m[i] = image[i];
        for (i = 0; i < 16; i++) r[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 5000) begin
            w = m[pc[addr_width-1:0]];
            pc = pc + 1;
            ra = w[26:23];
            rb = w[22:19];
            rc = w[18:15];
            c = {{13{w[18]}}, w[18:0]};
            base = (rb == 4'd0) ? '0 : r[rb];  // r0 as a base is zero
            ea = base + c;
            n = r[rc][4:0];
            case (w[31:27])
                op_ld:   r[ra] = m[ea[addr_width-1:0]];
                op_ldi:  r[ra] = ea;
                op_st: begin
                    m[ea[addr_width-1:0]] = r[ra];
                    exp_addr.push_back(ea[addr_width-1:0]);
                    exp_data.push_back(r[ra]);
                end
                op_add:  r[ra] = r[rb] + r[rc];
                op_sub:  r[ra] = r[rb] - r[rc];
                op_and:  r[ra] = r[rb] & r[rc];
                op_or:   r[ra] = r[rb] | r[rc];
                op_shr:  r[ra] = r[rb] >> n;
                op_shra: begin
                    sv = r[rb];
                    r[ra] = sv >>> n;
                end
                op_shl:  r[ra] = r[rb] << n;
                op_ror:  r[ra] = (r[rb] >> n) | (r[rb] << (32 - n));  // n = 0 leaves it whole
                op_rol:  r[ra] = (r[rb] << n) | (r[rb] >> (32 - n));
                op_addi: r[ra] = r[rb] + c;
                op_andi: r[ra] = r[rb] & c;
                op_ori:  r[ra] = r[rb] | c;
                op_neg:  r[ra] = -r[rb];
                op_not:  r[ra] = ~r[rb];
                op_br: begin
                    v = r[ra];
                    case (w[20:19])
                        cond_zero:     taken = (v == 32'd0);
                        cond_nonzero:  taken = (v != 32'd0);
                        cond_positive: taken = !v[31];
                        default:       taken = v[31];
                    endcase
                    if (taken) begin
                        if (c == 32'hffff_ffff) halted = 1'b1;  // branch onto itself
                        pc = pc + c;
                    end
                end
                default: ;  // nop and unknown codes
            endcase
            steps++;
        end
        run_model = halted ? exp_addr.size() : -1;
    endfunction

    // strobes and bus values are settled at the falling edge
    always @(negedge clk) begin
        if (image_ready && !model_done) begin
            expected = run_model();
            model_done = 1'b1;
            if (expected < 0) begin
                $display("reference model never reached the closing branch loop");
                errors++;
                expected = exp_addr.size();
            end
        end
        if (reset) begin
            if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
                $display("memory strobe not low during reset at %0t ns", $time);
                errors++;
            end
        end else if (mem_write) begin
            if (seen >= exp_addr.size()) begin
                $display("unexpected write at %0t ns to address %h, all %0d writes already seen",
                         $time, mem_addr, exp_addr.size());
                errors++;
            end else begin
                if (mem_addr !== exp_addr[seen]) begin
                    $display("Fail at %0t ns: mem_addr is %h, expected %h",
                             $time, mem_addr, exp_addr[seen]);
                    errors++;
                end
                if (mem_wdata !== exp_data[seen]) begin
                    $display("Fail at %0t ns: mem_wdata is %h, expected %h",
                             $time, mem_wdata, exp_data[seen]);
                    errors++;
                end
            end
            seen++;
        end
    end

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;
    import cpu_isa_pkg::*;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        stop = 1'b0;
    logic [8:0]  mem_addr;
    logic [31:0] mem_rdata = '0;
    logic [31:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;

    logic [31:0] image [512];
    logic [31:0] mem [512];
    logic        image_ready = 1'b0;
    logic        wr_pend = 1'b0;
    logic [8:0]  wr_addr;
    logic [31:0] wr_data;
    integer      seed;
    int          pc_ptr;
    int          slot;
    int          tb_errors = 0;
    int          chk_seen;
    int          chk_expect;
    int          chk_errors;
    int          br_reg [8] = '{13, 14, 14, 13, 14, 15, 15, 14};  // r13 zero, r14 > 0, r15 < 0

    always #5 clk = ~clk;

    cpu_top #(.addr_width(9)) dut (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    cpu_checker #(.addr_width(9)) chk (
        .clk          (clk),
        .reset        (reset),
        .image_ready  (image_ready),
        .image        (image),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .seen_count   (chk_seen),
        .expect_count (chk_expect),
        .error_count  (chk_errors)
    );

    // write captured mid-cycle, lands with the edge that ends it
    always @(negedge clk) begin
        wr_pend = mem_write;
        wr_addr = mem_addr;
        wr_data = mem_wdata;
    end

    always @(posedge clk) begin
        #1;
        if (reset) mem = image;
        else if (wr_pend) mem[wr_addr] = wr_data;
        mem_rdata = mem[mem_addr];  // asynchronous read of the new MAR
    end

    function automatic logic [31:0] enc_r(input logic [4:0] op, input int ra, input int rb,
                                          input int rc);
        enc_r = {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
    endfunction

    function automatic logic [31:0] enc_i(input logic [4:0] op, input int ra, input int rb,
                                          input int c);
        enc_i = {op, 4'(ra), 4'(rb), 19'(c)};
    endfunction

    function automatic logic [31:0] enc_br(input int ra, input int cond, input int c);
        enc_br = {op_br, 4'(ra), 2'b00, 2'(cond), 19'(c)};
    endfunction

    function automatic logic [4:0] reg_op(input int k);
        case (k)
            0:       reg_op = op_add;
            1:       reg_op = op_sub;
            2:       reg_op = op_and;
            3:       reg_op = op_or;
            4:       reg_op = op_shr;
            5:       reg_op = op_shra;
            6:       reg_op = op_shl;
            7:       reg_op = op_ror;
            default: reg_op = op_rol;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        image[pc_ptr] = w;
        pc_ptr++;
    endtask

    task automatic store_result(input int r);
        emit(enc_i(op_st, r, 3, slot));  // next free word above r3
        slot++;
    endtask

    task automatic build_image();
        int i;
        int k;
        int n;
        seed = 32'hcafd655e;
        for (i = 0; i < 512; i++) image[i] = 32'hd00d_0000 | 32'(i);  // decodes as nop
        for (i = 256; i < 272; i++) image[i] = $random(seed);
        image[258][31] = 1'b1;  // negative operand for shra
        pc_ptr = 0;
        slot = 0;
        emit(enc_i(op_ldi, 0, 0, 'h2a5));  // junk in r0 that a base must ignore
        emit(enc_i(op_ld, 1, 0, 256));  // r0 base reads as zero
        emit(enc_i(op_ld, 2, 0, 257));
        emit(enc_i(op_ld, 7, 0, 258));
        emit(enc_i(op_ld, 8, 0, 259));
        emit(enc_i(op_ldi, 3, 0, 384));  // result area
        emit(enc_i(op_ldi, 4, 3, 100));
        store_result(1);
        store_result(2);
        store_result(4);
        emit(enc_i(op_ld, 5, 4, -99));  // back from slot 1
        store_result(5);
        emit(enc_i(op_st, 7, 4, 20));
        for (k = 0; k < 8; k++) begin
            emit(enc_r(reg_op(k % 4), 6, (k < 4) ? 1 : 7, (k < 4) ? 2 : 8));
            store_result(6);
        end
        emit(enc_i(op_addi, 6, 1, -12345));
        store_result(6);
        emit(enc_i(op_addi, 6, 8, 200000));
        store_result(6);
        emit(enc_i(op_andi, 6, 7, -1234));
        store_result(6);
        emit(enc_i(op_ori, 6, 2, 'h1abcd));
        store_result(6);
        for (k = 0; k < 9; k++) begin
            n = (k == 8) ? 31 : 4 * k;
            emit(enc_i(op_ldi, 9, 0, n));  // shift count in r9
            for (i = 4; i < 9; i++) begin
                emit(enc_r(reg_op(i), 6, (k % 2 == 1) ? 1 : 7, 9));
                store_result(6);
            end
        end
        for (k = 0; k < 2; k++) begin
            emit(enc_r(op_neg, 6, (k == 0) ? 1 : 7, 0));
            store_result(6);
            emit(enc_r(op_not, 6, (k == 0) ? 1 : 7, 0));
            store_result(6);
        end
        emit(enc_i(op_ldi, 13, 0, 0));
        emit(enc_i(op_ldi, 14, 0, 77));
        emit(enc_i(op_ldi, 15, 0, -5));
        for (k = 0; k < 8; k++) begin
            emit(enc_i(op_ldi, 11, 0, 'h100 + k));  // marker of the fall-through path
            emit(enc_i(op_ldi, 12, 0, 'h200 + k));
            emit(enc_br(br_reg[k], k / 2, 1));  // taken skips one store
            store_result(11);
            store_result(12);
        end
        emit(enc_br(13, 0, -1));  // final loop
    endtask

    task automatic wait_for_writes(input int n, input int limit, input string what,
                                   output bit ok);
        int cycles;
        ok = 1'b0;
        for (cycles = 0; chk_seen < n; cycles++) begin
            if (cycles >= limit) begin
                $display("timeout after %0d cycles waiting for %s, %0d of %0d writes seen",
                         limit, what, chk_seen, n);
                tb_errors++;
                return;
            end
            @(posedge clk);
        end
        ok = 1'b1;
    endtask

    task automatic run_phases();
        int k;
        bit ok;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        if (chk_expect < 2) begin
            $display("reference model gave only %0d writes", chk_expect);
            tb_errors++;
            return;
        end
        wait_for_writes(chk_expect / 2, 5000, "writes before stop", ok);
        if (!ok) return;
        #1;
        stop = 1'b1;  // the store just seen is the current instruction
        for (k = 0; k < 50; k++) begin
            @(negedge clk);
            if (mem_write || mem_read) begin
                $display("memory access at %0t ns while stop was held", $time);
                tb_errors++;
            end
        end
        @(posedge clk);
        #1;
        stop = 1'b0;
        wait_for_writes(chk_expect, 20000, "the remaining writes", ok);
        if (!ok) return;
        repeat (20) @(posedge clk);  // final loop runs, room for a stray write to show up
        #1;
        stop = 1'b1;
    endtask

    initial begin
        build_image();
        image_ready = 1'b1;
        run_phases();
        $display("errors: %0d in the checker, %0d in the testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/ctrl_bus_if.sv
logic/alu.sv
logic/control_unit.sv
logic/datapath.sv
logic/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv
